// ==== hw/pet_defines.svh ====
`ifndef PET_DEFINES_SVH
`define PET_DEFINES_SVH

// Game timing
// Small divider for simulation, the board build uses a large one
`define PET_TICK_DIV 8

// Ticks between two decay or recovery steps
`define PET_DECAY_TICKS 6

// Level limits of every need
`define PET_LEVEL_MAX 10  // Shown as "A"
`define PET_LEVEL_INIT 8  // After reset and game reset

// Face turns happy at this level
`define PET_HAPPY_MIN 5

`endif

// ==== hw/pet_pkg.sv ====
package pet_pkg;

    // The four needs, also the bit index into feed and buttons
    typedef enum logic [1:0] {
        NEED_HEALTH = 2'd0,
        NEED_ENERGY = 2'd1,
        NEED_HUNGER = 2'd2,
        NEED_FUN    = 2'd3
    } need_e;

    // Game mode
    typedef enum logic {
        MODE_NORMAL = 1'b0,
        MODE_TEST   = 1'b1  // No decay, presses toggle 1 <-> 10
    } mode_e;

    // One need level, 0 to 10
    typedef logic [3:0] pet_level_t;

    // Commands sampled on a game tick
    typedef struct packed {
        logic [3:0] feed;  // One bit per need_e
        logic test_req;    // Enter test mode
        logic game_reset;  // Restore all levels
    } pet_cmd_t;

    // All four levels together
    typedef struct packed {
        pet_level_t health;
        pet_level_t energy;
        pet_level_t hunger;
        pet_level_t fun;
    } pet_levels_t;

    // What the display block shows
    typedef struct packed {
        need_e sel;       // Last selected need
        logic happy;      // Face
        logic [6:0] seg;  // gfedcba, active high
        mode_e mode;
        logic spare;      // Always zero
    } pet_view_t;

endpackage

// ==== hw/pet_button_sampler.sv ====
`include "pet_defines.svh"

module pet_button_sampler import pet_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic [3:0] btn_need,  // Indexed by need_e
    input  logic btn_test,
    input  logic btn_reset,
    output logic tick,            // One cycle per game tick
    output logic blink,           // Toggles on every tick
    output pet_cmd_t cmd          // Valid while tick is high
);

    localparam int CNT_W = $clog2(`PET_TICK_DIV + 1);
    localparam int NUM_BTN = 6;

    logic [CNT_W-1:0] tick_cnt;  // Cycles within a tick
    logic tick_end;              // Last cycle before a tick

    logic [NUM_BTN-1:0] btn_raw;  // {need[3:0], test, reset}
    logic [NUM_BTN-1:0] sync_1;   // First synchroniser stage
    logic [NUM_BTN-1:0] sync_2;   // Second stage, safe to use
    logic [NUM_BTN-1:0] btn_prev; // For edge detection
    logic [NUM_BTN-1:0] btn_rise; // Rising edges this cycle
    logic [NUM_BTN-1:0] pending;  // Presses since the last tick
    logic [NUM_BTN-1:0] taken;    // Presses handed to the tick

    assign tick_end = (tick_cnt == CNT_W'(`PET_TICK_DIV - 1));

    // Tick divider, first tick PET_TICK_DIV cycles after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
            tick <= 1'b0;
            blink <= 1'b0;
        end else begin
            tick <= tick_end;             // Registered pulse
            if (tick_end) begin
                tick_cnt <= '0;
                blink <= ~blink;          // Visible heartbeat
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign btn_raw = {btn_need, btn_test, btn_reset};
    assign btn_rise = sync_2 & ~btn_prev;
    assign taken = pending | btn_rise;  // Edge on the tick edge still counts

    // Synchroniser, edge detect and press latch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_1 <= '0;
            sync_2 <= '0;
            btn_prev <= '0;
            pending <= '0;
        end else begin
            sync_1 <= btn_raw;
            sync_2 <= sync_1;
            btn_prev <= sync_2;
            if (tick_end) begin
                pending <= '0;            // Copied into cmd below
            end else begin
                pending <= taken;         // Presses merge until tick
            end
        end
    end

    // Command word, loaded together with the tick pulse
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd <= '0;
        end else if (tick_end) begin
            cmd.feed <= taken[5:2];
            cmd.test_req <= taken[1];
            cmd.game_reset <= taken[0];
        end
    end

endmodule

// ==== hw/pet_mode_ctrl.sv ====
module pet_mode_ctrl import pet_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic tick,
    input  pet_cmd_t cmd,
    input  logic rest,    // Lights off, gates the energy button
    output mode_e mode,
    output need_e sel,    // Need on the display
    output logic clear    // Game reset, for the tick cycle
);

    mode_e mode_next;
    need_e sel_next;
    logic [3:0] feed_ok;  // Feed bits that may select

    // Game reset wins over every other command
    assign clear = tick & cmd.game_reset;

    // Mode FSM
    always_comb begin
        mode_next = mode;
        if (cmd.game_reset) begin
            mode_next = MODE_NORMAL;      // Leave test mode
        end else if (cmd.test_req) begin
            mode_next = MODE_TEST;
        end
    end

    // Lowest indexed fed need becomes the selection
    always_comb begin
        feed_ok = cmd.feed;
        feed_ok[NEED_ENERGY] = cmd.feed[NEED_ENERGY] & rest;  // Awake pet ignores it
        sel_next = sel;
        for (int i = 3; i >= 0; i--) begin
            if (feed_ok[i]) begin
                sel_next = need_e'(i);    // Lower index overrides
            end
        end
        if (cmd.game_reset) begin
            sel_next = NEED_HEALTH;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode <= MODE_NORMAL;
            sel <= NEED_HEALTH;
        end else if (tick) begin          // cmd only valid now
            mode <= mode_next;
            sel <= sel_next;
        end
    end

endmodule

// ==== hw/pet_need_counter.sv ====
`include "pet_defines.svh"

module pet_need_counter import pet_pkg::*; #(
    parameter bit RECOVER_ON_REST = 1'b0  // Energy style need
) (
    input  logic clk,
    input  logic reset,
    input  logic tick,
    input  logic feed,         // This need's button, tick cycle only
    input  logic rest,         // Lights off
    input  mode_e mode,
    input  logic clear,        // Game reset strobe
    output pet_level_t level
);

    localparam int TIMER_W = $clog2(`PET_DECAY_TICKS + 1);
    localparam pet_level_t LVL_MAX = pet_level_t'(`PET_LEVEL_MAX);
    localparam pet_level_t LVL_INIT = pet_level_t'(`PET_LEVEL_INIT);
    localparam pet_level_t LVL_LOW = pet_level_t'(1);  // Test mode low value

    logic [TIMER_W-1:0] timer;  // Ticks since the last step
    logic step;                 // Decay or recovery due
    logic feed_ok;              // Accepted press
    logic recover;              // Step goes up instead of down

    assign step = (timer == TIMER_W'(`PET_DECAY_TICKS - 1));
    assign recover = RECOVER_ON_REST && rest;
    // Energy can only be fed while resting
    assign feed_ok = feed && (!RECOVER_ON_REST || rest);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            level <= LVL_INIT;
            timer <= '0;
        end else if (tick) begin
            if (clear) begin
                level <= LVL_INIT;        // Game reset
                timer <= '0;
            end else if (mode == MODE_TEST) begin
                timer <= '0;              // Decay frozen
                if (feed_ok) begin
                    // Toggle between the two test values
                    level <= (level == LVL_LOW) ? LVL_MAX : LVL_LOW;
                end
            end else begin
                // Timer runs on every normal tick
                if (step) begin
                    timer <= '0;
                end else begin
                    timer <= timer + 1'b1;
                end
                if (feed_ok) begin
                    if (level < LVL_MAX) begin
                        level <= level + 1'b1;  // Feed, saturating
                    end
                end else if (step) begin
                    if (recover) begin
                        if (level < LVL_MAX) begin
                            level <= level + 1'b1;  // Sleeping recovers
                        end
                    end else if (level != '0) begin
                        level <= level - 1'b1;  // Decay, stops at 0
                    end
                end
            end
        end
    end

endmodule

// ==== hw/pet_display.sv ====
`include "pet_defines.svh"

module pet_display import pet_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  pet_levels_t levels,
    input  need_e sel,
    input  mode_e mode,
    output pet_view_t view   // Registered, one cycle behind
);

    pet_level_t shown;       // Level of the selected need

    // Digit encoder, gfedcba active high
    function automatic logic [6:0] seg_code(input pet_level_t lvl);
        case (lvl)
            4'd0: seg_code = 7'b0111111;
            4'd1: seg_code = 7'b0000110;
            4'd2: seg_code = 7'b1011011;
            4'd3: seg_code = 7'b1001111;
            4'd4: seg_code = 7'b1100110;
            4'd5: seg_code = 7'b1101101;
            4'd6: seg_code = 7'b1111101;
            4'd7: seg_code = 7'b0000111;
            4'd8: seg_code = 7'b1111111;
            4'd9: seg_code = 7'b1101111;
            4'd10: seg_code = 7'b1110111;  // "A" for full
            default: seg_code = 7'b0000000;  // Blank
        endcase
    endfunction

    always_comb begin
        case (sel)
            NEED_HEALTH: shown = levels.health;
            NEED_ENERGY: shown = levels.energy;
            NEED_HUNGER: shown = levels.hunger;
            default: shown = levels.fun;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            view.sel <= NEED_HEALTH;
            view.happy <= (`PET_LEVEL_INIT >= `PET_HAPPY_MIN);  // Initial face
            view.seg <= seg_code(pet_level_t'(`PET_LEVEL_INIT));
            view.mode <= MODE_NORMAL;
            view.spare <= 1'b0;
        end else begin
            view.sel <= sel;
            view.happy <= (shown >= pet_level_t'(`PET_HAPPY_MIN));
            view.seg <= seg_code(shown);
            view.mode <= mode;
            view.spare <= 1'b0;
        end
    end

endmodule

// ==== hw/pet_top.sv ====
module pet_top import pet_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic [3:0] btn_need,   // Indexed by need_e
    input  logic btn_test,
    input  logic btn_reset,        // Game reset button
    input  logic rest,             // Lights off
    output pet_levels_t levels,
    output pet_view_t view,
    output logic blink             // Tick heartbeat
);

    logic tick;       // Game tick enable
    pet_cmd_t cmd;    // Commands of this tick
    mode_e mode;
    need_e sel;
    logic clear;      // Game reset strobe

    pet_button_sampler u_sampler (
        .clk(clk),
        .reset(reset),
        .btn_need(btn_need),
        .btn_test(btn_test),
        .btn_reset(btn_reset),
        .tick(tick),
        .blink(blink),
        .cmd(cmd)
    );

    pet_mode_ctrl u_mode (
        .clk(clk),
        .reset(reset),
        .tick(tick),
        .cmd(cmd),
        .rest(rest),
        .mode(mode),
        .sel(sel),
        .clear(clear)
    );

    pet_need_counter #(.RECOVER_ON_REST(1'b0)) u_health (
        .clk(clk), .reset(reset), .tick(tick),
        .feed(cmd.feed[NEED_HEALTH]), .rest(rest),
        .mode(mode), .clear(clear), .level(levels.health)
    );

    // Only energy recovers while resting
    pet_need_counter #(.RECOVER_ON_REST(1'b1)) u_energy (
        .clk(clk), .reset(reset), .tick(tick),
        .feed(cmd.feed[NEED_ENERGY]), .rest(rest),
        .mode(mode), .clear(clear), .level(levels.energy)
    );

    pet_need_counter #(.RECOVER_ON_REST(1'b0)) u_hunger (
        .clk(clk), .reset(reset), .tick(tick),
        .feed(cmd.feed[NEED_HUNGER]), .rest(rest),
        .mode(mode), .clear(clear), .level(levels.hunger)
    );

    pet_need_counter #(.RECOVER_ON_REST(1'b0)) u_fun (
        .clk(clk), .reset(reset), .tick(tick),
        .feed(cmd.feed[NEED_FUN]), .rest(rest),
        .mode(mode), .clear(clear), .level(levels.fun)
    );

    pet_display u_display (
        .clk(clk),
        .reset(reset),
        .levels(levels),
        .sel(sel),
        .mode(mode),
        .view(view)
    );

endmodule

// ==== verification/pet_props.sv ====
`include "pet_defines.svh"

module pet_props import pet_pkg::*; (
    input logic clk,
    input logic reset,
    input logic tick,            // Game tick enable inside pet_top
    input pet_cmd_t cmd,         // Sampler command word
    input mode_e mode,
    input pet_levels_t levels
);

    localparam pet_level_t LVL_MAX = pet_level_t'(`PET_LEVEL_MAX);

    // Tick is a single-cycle strobe
    tick_one_cycle: assert property (@(posedge clk) disable iff (reset)
        tick |=> !tick)
        else $error("tick stayed high for more than one cycle");

    // Saturation keeps every need at or below the maximum
    levels_in_range: assert property (@(posedge clk) disable iff (reset)
        (levels.health <= LVL_MAX) && (levels.energy <= LVL_MAX) &&
        (levels.hunger <= LVL_MAX) && (levels.fun <= LVL_MAX))
        else $error("a need level is above the maximum");

    // Test mode freezes decay, only tick commands move a level
    test_mode_frozen: assert property (@(posedge clk) disable iff (reset)
        (mode == MODE_TEST && !tick) |=> $stable(levels))
        else $error("a level moved in test mode without a tick");

    // Command word is loaded together with the tick pulse
    cmd_with_tick: assert property (@(posedge clk) disable iff (reset)
        !$stable(cmd) |-> tick)
        else $error("cmd changed outside a tick");

endmodule

bind pet_top pet_props i_props (
    .clk(clk),
    .reset(reset),
    .tick(tick),
    .cmd(cmd),
    .mode(mode),
    .levels(levels)
);

// ==== verification/pet_tb.sv ====
`include "pet_defines.svh"

module pet_tb import pet_pkg::*; ();

    typedef enum logic [2:0] {
        ACT_WAIT,   // arg is the tick count
        ACT_NEED,   // arg is the need index
        ACT_TEST,
        ACT_RESET,
        ACT_REST    // arg is the new rest level
    } act_e;

    typedef struct packed {
        act_e act;
        logic [7:0] arg;
        pet_levels_t levels;  // Expected once the row is done
        need_e sel;
        logic happy;
        mode_e mode;
    } row_t;

    logic clk;
    logic reset;
    logic [3:0] btn_need;
    logic btn_test;
    logic btn_reset;
    logic rest;
    pet_levels_t levels;
    pet_view_t view;
    logic blink;

    row_t rows[$];
    string names[$];
    logic [6:0] digit_seg [0:15];  // gfedcba per level
    int level_errs = 0;
    int view_errs = 0;
    int seg_errs = 0;
    int tick_errs = 0;
    int watch_limit = 0;           // Zero until the table is built
    int tick_gap = 0;              // Falling edges since the last blink toggle
    logic last_blink = 1'b0;       // Reset level of blink

    pet_top i_dut (
        .clk(clk),
        .reset(reset),
        .btn_need(btn_need),
        .btn_test(btn_test),
        .btn_reset(btn_reset),
        .rest(rest),
        .levels(levels),
        .view(view),
        .blink(blink)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic pet_levels_t levels_of(input int h, input int e, input int hu, input int f);
        pet_levels_t lv;
        lv.health = pet_level_t'(h);
        lv.energy = pet_level_t'(e);
        lv.hunger = pet_level_t'(hu);
        lv.fun = pet_level_t'(f);
        return lv;
    endfunction

    function automatic pet_level_t selected_level(input pet_levels_t lv, input need_e sel);
        case (sel)
            NEED_HEALTH: return lv.health;
            NEED_ENERGY: return lv.energy;
            NEED_HUNGER: return lv.hunger;
            default: return lv.fun;
        endcase
    endfunction

    function automatic int row_ticks(input row_t r);
        case (r.act)
            ACT_WAIT: return int'(r.arg);
            ACT_REST: return 1;
            default: return 2;               // Press tick plus one
        endcase
    endfunction

    task automatic fill_digits();
        for (int i = 0; i < 16; i++) begin
            digit_seg[i] = 7'b0000000;       // Blank above A
        end
        digit_seg[0] = 7'b0111111;
        digit_seg[1] = 7'b0000110;
        digit_seg[2] = 7'b1011011;
        digit_seg[3] = 7'b1001111;
        digit_seg[4] = 7'b1100110;
        digit_seg[5] = 7'b1101101;
        digit_seg[6] = 7'b1111101;
        digit_seg[7] = 7'b0000111;
        digit_seg[8] = 7'b1111111;
        digit_seg[9] = 7'b1101111;
        digit_seg[10] = 7'b1110111;          // Letter A
    endtask

    task automatic add_row(input string name, input act_e act, input int arg,
                           input pet_levels_t lv, input need_e sel, input logic happy,
                           input mode_e mode);
        row_t r;
        r.act = act;
        r.arg = 8'(arg);
        r.levels = lv;
        r.sel = sel;
        r.happy = happy;
        r.mode = mode;
        rows.push_back(r);
        names.push_back(name);
    endtask

    // Decay steps land on ticks 6, 12, 18 and 24, then 46 after the game reset on tick 40
    task automatic build_table();
        add_row("after reset", ACT_WAIT, 0, levels_of(8, 8, 8, 8), NEED_HEALTH, 1'b1, MODE_NORMAL);
        add_row("first tick", ACT_WAIT, 1, levels_of(8, 8, 8, 8), NEED_HEALTH, 1'b1, MODE_NORMAL);
        add_row("feed hunger 1", ACT_NEED, int'(NEED_HUNGER), levels_of(8, 8, 9, 8),
                NEED_HUNGER, 1'b1, MODE_NORMAL);
        add_row("feed hunger 2", ACT_NEED, int'(NEED_HUNGER), levels_of(8, 8, 10, 8),
                NEED_HUNGER, 1'b1, MODE_NORMAL);
        add_row("feed hunger full", ACT_NEED, int'(NEED_HUNGER), levels_of(7, 7, 10, 7),
                NEED_HUNGER, 1'b1, MODE_NORMAL);  // Feed beats the step
        add_row("decay rest low", ACT_WAIT, 6, levels_of(6, 6, 9, 6), NEED_HUNGER, 1'b1, MODE_NORMAL);
        add_row("lights off", ACT_REST, 1, levels_of(6, 6, 9, 6), NEED_HUNGER, 1'b1, MODE_NORMAL);
        add_row("decay rest high", ACT_WAIT, 6, levels_of(5, 7, 8, 5), NEED_HUNGER, 1'b1, MODE_NORMAL);
        add_row("lights on", ACT_REST, 0, levels_of(5, 7, 8, 5), NEED_HUNGER, 1'b1, MODE_NORMAL);
        add_row("energy while awake", ACT_NEED, int'(NEED_ENERGY), levels_of(5, 7, 8, 5),
                NEED_HUNGER, 1'b1, MODE_NORMAL);
        add_row("enter test mode", ACT_TEST, 0, levels_of(4, 6, 7, 4), NEED_HUNGER, 1'b1, MODE_TEST);
        add_row("test mode hold", ACT_WAIT, 10, levels_of(4, 6, 7, 4), NEED_HUNGER, 1'b1, MODE_TEST);
        add_row("test fun low", ACT_NEED, int'(NEED_FUN), levels_of(4, 6, 7, 1),
                NEED_FUN, 1'b0, MODE_TEST);
        add_row("test fun high", ACT_NEED, int'(NEED_FUN), levels_of(4, 6, 7, 10),
                NEED_FUN, 1'b1, MODE_TEST);
        add_row("game reset", ACT_RESET, 0, levels_of(8, 8, 8, 8), NEED_HEALTH, 1'b1, MODE_NORMAL);
        add_row("decay after reset", ACT_WAIT, 6, levels_of(7, 7, 7, 7), NEED_HEALTH, 1'b1, MODE_NORMAL);
        add_row("lights off again", ACT_REST, 1, levels_of(7, 7, 7, 7), NEED_HEALTH, 1'b1, MODE_NORMAL);
        add_row("feed energy asleep", ACT_NEED, int'(NEED_ENERGY), levels_of(7, 8, 7, 7),
                NEED_ENERGY, 1'b1, MODE_NORMAL);
    endtask

    task automatic set_button(input int which, input logic value);
        if (which < 4) begin
            btn_need[2'(which)] = value;
        end else if (which == 4) begin
            btn_test = value;
        end else begin
            btn_reset = value;
        end
    endtask

    // One falling edge, a blink toggle must come every PET_TICK_DIV cycles
    task automatic next_cycle(input string name, output logic toggled);
        @(negedge clk);
        tick_gap++;
        toggled = 1'b0;
        if (blink !== last_blink) begin
            check_tick_gap(name, `PET_TICK_DIV, tick_gap);
            last_blink = blink;
            tick_gap = 0;
            toggled = 1'b1;
        end
    endtask

    // Counts blink toggles on falling edges, which = -1 holds no button
    task automatic run_ticks(input string name, input int n, input int which, input int hold);
        int seen;
        int cycles;
        logic toggled;
        seen = 0;
        cycles = 0;
        if (which >= 0) begin
            set_button(which, 1'b1);
        end
        while (seen < n) begin
            next_cycle(name, toggled);
            cycles++;
            if (which >= 0 && cycles == hold) begin
                set_button(which, 1'b0);
            end
            if (toggled) begin
                seen++;
            end
        end
        if (which >= 0) begin
            set_button(which, 1'b0);
        end
        repeat (2) next_cycle(name, toggled);  // Levels, then the view register
    endtask

    task automatic check_levels(input string name, input pet_levels_t exp, input pet_levels_t act);
        if (act !== exp) begin
            level_errs++;
            $display("Mismatch %s levels: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_view(input string name, input pet_view_t exp, input pet_view_t act);
        pet_view_t e;
        pet_view_t a;
        e = exp;
        a = act;
        e.seg = '0;                          // Segments have their own check
        a.seg = '0;
        if (a !== e) begin
            view_errs++;
            $display("Mismatch %s view: expected %h, actual %h", name, e, a);
        end
    endtask

    task automatic check_seg(input string name, input logic [6:0] exp, input logic [6:0] act);
        if (act !== exp) begin
            seg_errs++;
            $display("Mismatch %s seg: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_tick_gap(input string name, input int exp, input int act);
        if (act != exp) begin
            tick_errs++;
            $display("Mismatch %s tick period: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic run_row(input int idx);
        row_t r;
        pet_view_t exp_view;
        int hold;
        r = rows[idx];
        hold = 3 + int'($urandom % 8);       // 3 to 10 cycles
        case (r.act)
            ACT_WAIT: run_ticks(names[idx], int'(r.arg), -1, 0);
            ACT_NEED: run_ticks(names[idx], 2, int'(r.arg), hold);
            ACT_TEST: run_ticks(names[idx], 2, 4, hold);
            ACT_RESET: run_ticks(names[idx], 2, 5, hold);
            default: begin
                rest = r.arg[0];
                run_ticks(names[idx], 1, -1, 0);
            end
        endcase
        exp_view.sel = r.sel;
        exp_view.happy = r.happy;
        exp_view.seg = digit_seg[selected_level(r.levels, r.sel)];
        exp_view.mode = r.mode;
        exp_view.spare = 1'b0;
        check_levels(names[idx], r.levels, levels);
        check_view(names[idx], exp_view, view);
        check_seg(names[idx], exp_view.seg, view.seg);
    endtask

    initial begin
        int total;
        void'($urandom(32'h4da79492));
        reset = 1'b1;
        btn_need = 4'b0000;
        btn_test = 1'b0;
        btn_reset = 1'b0;
        rest = 1'b0;
        fill_digits();
        build_table();
        total = 0;
        foreach (rows[i]) begin
            total += row_ticks(rows[i]);
        end
        watch_limit = (total + 20) * `PET_TICK_DIV * 100 + 40 * 100;  // Margin plus reset
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (rows[i]) begin
            run_row(i);
        end
        $display("Done %0d rows: level errors %0d, view errors %0d, seg errors %0d, tick errors %0d",
                 rows.size(), level_errs, view_errs, seg_errs, tick_errs);
        if (level_errs + view_errs + seg_errs + tick_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (watch_limit != 0);
        #(watch_limit);
        $display("Watchdog expired at %0t, the table did not finish in time", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+hw
hw/pet_pkg.sv
hw/pet_button_sampler.sv
hw/pet_mode_ctrl.sv
hw/pet_need_counter.sv
hw/pet_display.sv
hw/pet_top.sv
verification/pet_props.sv
verification/pet_tb.sv

// ==== Makefile ====
# Verilator flow for the virtual-pet controller

VERILATOR ?= verilator
TOP ?= pet_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
